// ==== rv32e_pipe.f ====
verilog/rv32e_pkg.sv
verilog/fetch_stage.sv
verilog/imm_gen.sv
verilog/reg_file.sv
verilog/pipe_ctrl.sv
verilog/exec_stage.sv
verilog/rv32e_core.sv
tb/rv32e_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the result from the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module rv32e_core_tb -f rv32e_pipe.f -o sim
./obj_dir/sim > sim.log 2>&1
cat sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    exit 0
else
    exit 1
fi

// ==== tb/rv32e_core_tb.sv ====
// Directed tests for rv32e_core; memories answer combinationally, data port sampled at negedge
`timescale 1ns/1ps
`default_nettype none

module rv32e_core_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 4;
    localparam int IMEM_WORDS   = 128;
    localparam int DMEM_WORDS   = 64;
    localparam int NUM_TESTS    = 5;
    // Every test is bounded by a full instruction memory plus drain and reset
    localparam int WATCHDOG_NS  = NUM_TESTS * (IMEM_WORDS + 8 + RESET_CYCLES + 4) * CLK_PERIOD
                                  + 1000;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [31:0] instr_addr;
    logic [31:0] instr_data;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        mem_we;
    logic        mem_re;
    logic [31:0] mem_rdata;
    logic [31:0] ioff;

    logic [31:0] imem [0:IMEM_WORDS-1];
    logic [31:0] dmem [0:DMEM_WORDS-1];
    logic [31:0] em [0:DMEM_WORDS-1];    // Expected data memory
    logic [31:0] model [0:15];           // Expected register values
    logic [31:0] prog [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] exp_ld_addr [$];
    logic [31:0] st_addr_q [$];
    logic [31:0] st_data_q [$];
    logic [31:0] ld_addr_q [$];
    logic [31:0] lfsr = 32'h92e6_a362;
    int          errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    rv32e_core dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_addr_o (instr_addr),
        .instr_data_i (instr_data),
        .mem_addr_o   (mem_addr),
        .mem_wdata_o  (mem_wdata),
        .mem_we_o     (mem_we),
        .mem_re_o     (mem_re),
        .mem_rdata_i  (mem_rdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Fetch outside the program returns NOPs
    assign ioff       = instr_addr - rv32e_pkg::RESET_PC;
    assign instr_data = (ioff < 32'(IMEM_WORDS * 4)) ? imem[ioff[8:2]] : rv32e_pkg::NOP_INSTR;
    assign mem_rdata  = dmem[mem_addr[7:2]];

    always @(negedge clk) begin
        if (rst_n && mem_we) begin
            dmem[mem_addr[7:2]] = mem_wdata;
            st_addr_q.push_back(mem_addr);
            st_data_q.push_back(mem_wdata);
        end
        if (rst_n && mem_re)
            ld_addr_q.push_back(mem_addr);    // Load strobe in its EX/MEM cycle
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] fill_word(input int idx);
        return 32'hc3a5_0000 ^ (idx << 22) ^ (idx << 2) ^ idx;
    endfunction

    // Reference results from the ISA definitions
    function automatic logic [31:0] alu_model(input logic alt, input logic [2:0] f3,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << sh;
            3'd2: return {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};    // Signed via bias
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? (a >> sh) | ({32{a[31]}} & ~(32'hffff_ffff >> sh)) : a >> sh;
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] enc_r(input logic alt, input logic [2:0] f3,
                                          input int rd, input int rs1, input int rs2);
        return {1'b0, alt, 5'b0, rs2[4:0], rs1[4:0], f3, rd[4:0], rv32e_pkg::OP_REG};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input int rs1,
                                          input logic [2:0] f3, input int rd,
                                          input logic [6:0] op);
        return {imm, rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input int rs2);
        return {imm[11:5], rs2[4:0], 5'd0, 3'b010, imm[4:0], rv32e_pkg::OP_STORE};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input int rd,
                                          input logic [6:0] op);
        return {imm, rd[4:0], op};
    endfunction

    task automatic set_reg(input int rd, input logic [31:0] v);
        if (rd != 0)
            model[rd] = v;    // x0 stays zero
    endtask

    task automatic op_r(input logic alt, input logic [2:0] f3, input int rd,
                        input int rs1, input int rs2);
        prog.push_back(enc_r(alt, f3, rd, rs1, rs2));
        set_reg(rd, alu_model(alt, f3, model[rs1], model[rs2]));
    endtask

    task automatic op_i(input logic [2:0] f3, input int rd, input int rs1, input logic [11:0] imm);
        prog.push_back(enc_i(imm, rs1, f3, rd, rv32e_pkg::OP_IMM));
        set_reg(rd, alu_model(f3 == 3'd5 && imm[10], f3, model[rs1], {{20{imm[11]}}, imm}));
    endtask

    task automatic lui(input int rd, input logic [19:0] imm);
        prog.push_back(enc_u(imm, rd, rv32e_pkg::OP_LUI));
        set_reg(rd, {imm, 12'h000});
    endtask

    task automatic auipc(input int rd, input logic [19:0] imm);
        logic [31:0] pc;
        pc = rv32e_pkg::RESET_PC + 32'(4 * prog.size());
        prog.push_back(enc_u(imm, rd, rv32e_pkg::OP_AUIPC));
        set_reg(rd, pc + {imm, 12'h000});
    endtask

    task automatic li(input int rd, input logic [31:0] v);
        logic [31:0] upper;
        upper = (v + 32'h800) >> 12;    // Rounds for the signed low part
        lui(rd, upper[19:0]);
        op_i(3'd0, rd, rd, v[11:0]);
    endtask

    task automatic sw(input int rs2, input int off);
        prog.push_back(enc_s(off[11:0], rs2));
        exp_addr.push_back(32'(off));
        exp_data.push_back(model[rs2]);
        em[off[7:2]] = model[rs2];
    endtask

    task automatic lw(input int rd, input int off);
        prog.push_back(enc_i(off[11:0], 0, 3'b010, rd, rv32e_pkg::OP_LOAD));
        exp_ld_addr.push_back(32'(off));
        set_reg(rd, em[off[7:2]]);
    endtask

    task automatic nop;
        prog.push_back(rv32e_pkg::NOP_INSTR);
    endtask

    task automatic begin_prog;
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
        exp_ld_addr.delete();
        for (int i = 0; i < 16; i++)
            model[i] = '0;
        for (int i = 0; i < DMEM_WORDS; i++)
            em[i] = fill_word(i);
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_stores;
        int n_seen;
        n_seen = st_addr_q.size();
        for (int i = 0; i < exp_addr.size(); i++) begin
            if (i >= n_seen) begin
                $display("Store %0d never reached the data port, %0d of %0d seen",
                         i, n_seen, exp_addr.size());
                errors++;
                break;
            end
            check_eq("mem_addr_o", st_addr_q[i], exp_addr[i]);
            check_eq("mem_wdata_o", st_data_q[i], exp_data[i]);
        end
        if (n_seen > exp_addr.size()) begin
            $display("Data port showed %0d stores but the program has only %0d",
                     n_seen, exp_addr.size());
            errors++;
        end
    endtask

    task automatic compare_loads;
        int n_seen;
        n_seen = ld_addr_q.size();
        if (n_seen != exp_ld_addr.size()) begin
            $display("Data port showed %0d loads with mem_re_o high but the program has %0d",
                     n_seen, exp_ld_addr.size());
            errors++;
        end
        for (int i = 0; i < n_seen && i < exp_ld_addr.size(); i++)
            check_eq("mem_addr_o", ld_addr_q[i], exp_ld_addr[i]);
    endtask

    // Reset, load memories, run to the end of the program, then check the data port
    task automatic run_prog;
        @(posedge clk);
        rst_n <= 1'b0;
        @(negedge clk);
        if (prog.size() > IMEM_WORDS) begin
            $display("Program of %0d words does not fit in instruction memory", prog.size());
            errors++;
        end
        for (int i = 0; i < IMEM_WORDS; i++)
            imem[i] = (i < prog.size()) ? prog[i] : rv32e_pkg::NOP_INSTR;
        for (int i = 0; i < DMEM_WORDS; i++)
            dmem[i] = fill_word(i);
        st_addr_q.delete();
        st_data_q.delete();
        ld_addr_q.delete();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (prog.size() + 8) @(posedge clk);    // One spare cycle per possible stall
        compare_stores();
        compare_loads();
    endtask

    task automatic report_test(input string name, input int err0);
        if (errors == err0) begin
            tests_passed++;
            $display("PASS: %s", name);
        end else begin
            tests_failed++;
            $display("FAIL: %s (%0d errors)", name, errors - err0);
        end
    endtask

    task automatic test_reset;
        int err0;
        err0 = errors;
        @(posedge clk);
        rst_n <= 1'b0;
        @(negedge clk);
        check_eq("instr_addr_o", instr_addr, rv32e_pkg::RESET_PC);
        check_eq("mem_we_o", 32'(mem_we), 32'h0);
        check_eq("mem_re_o", 32'(mem_re), 32'h0);
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);    // First cycle out of reset
        check_eq("instr_addr_o", instr_addr, rv32e_pkg::RESET_PC);
        check_eq("mem_we_o", 32'(mem_we), 32'h0);
        check_eq("mem_re_o", 32'(mem_re), 32'h0);
        report_test("reset state", err0);
    endtask

    task automatic test_alu;
        int err0;
        int off;
        logic [31:0] r;
        err0 = errors;
        off = 0;
        begin_prog();
        rand_bits(32, r);
        li(1, r & 32'h7fff_ffff);    // Positive
        rand_bits(32, r);
        li(3, r | 32'h8000_0000);    // Negative, for sign fill and SLT vs SLTU
        rand_bits(32, r);
        li(4, r);
        for (int p = 0; p < 2; p++) begin
            for (int k = 0; k < 10; k++) begin
                int f3v;
                f3v = (k < 8) ? k : ((k == 8) ? 0 : 5);    // Then SUB and SRA
                op_r(k >= 8, f3v[2:0], 5, (p == 0) ? 1 : 3, (p == 0) ? 3 : 4);
                sw(5, off);
                off += 4;
            end
        end
        for (int k = 0; k < 9; k++) begin
            logic [31:0] ri;
            logic [11:0] imm;
            int          f3v;
            rand_bits(12, ri);
            f3v = (k < 8) ? k : 5;
            imm = ri[11:0];
            if (f3v == 1 || f3v == 5)
                imm = {(k == 8) ? 7'h20 : 7'h00, ri[4:0]};    // SRAI on the last pass
            op_i(f3v[2:0], 6, 3, imm);
            sw(6, off);
            off += 4;
        end
        run_prog();
        report_test("alu operations", err0);
    endtask

    task automatic test_forwarding;
        int err0;
        logic [31:0] r;
        err0 = errors;
        begin_prog();
        rand_bits(32, r);
        li(1, r);
        op_i(3'd0, 2, 1, 12'h123);    // Distance 1 on rs1
        sw(2, 0);                     // Store data right after producer
        op_r(1'b0, 3'd0, 3, 2, 1);    // Distance 2 on rs1
        nop();
        op_r(1'b1, 3'd0, 4, 3, 2);
        nop();
        nop();
        op_r(1'b0, 3'd6, 5, 1, 4);    // Distance 3 on rs2
        sw(3, 4);
        sw(4, 8);
        sw(5, 12);
        op_r(1'b0, 3'd4, 6, 5, 3);
        op_r(1'b0, 3'd0, 7, 6, 6);
        nop();
        sw(7, 16);                    // Store data at distance 2
        op_r(1'b1, 3'd0, 8, 7, 1);
        nop();
        nop();
        sw(8, 20);                    // Store data at distance 3
        sw(6, 24);
        run_prog();
        report_test("back-to-back dependences", err0);
    endtask

    task automatic test_load_use;
        int err0;
        logic [31:0] r;
        err0 = errors;
        begin_prog();
        rand_bits(32, r);
        li(1, r);
        sw(1, 64);
        lw(2, 64);
        op_r(1'b0, 3'd0, 3, 2, 1);    // Stalls one cycle
        sw(3, 68);
        lw(4, 200);
        sw(4, 72);                    // Store of the loaded word also stalls
        lw(5, 204);
        op_i(3'd0, 5, 5, 12'h001);
        sw(5, 76);
        lw(6, 208);
        nop();
        op_r(1'b0, 3'd0, 7, 6, 6);    // No stall, load data from MEM/WB
        sw(7, 80);
        sw(1, 84);
        run_prog();
        report_test("load then use", err0);
    endtask

    task automatic test_upper_x0;
        int err0;
        logic [31:0] r;
        err0 = errors;
        begin_prog();
        rand_bits(20, r);
        lui(1, r[19:0]);
        sw(1, 0);
        rand_bits(20, r);
        auipc(2, r[19:0]);
        sw(2, 4);
        op_i(3'd0, 0, 1, 12'h7ff);
        op_r(1'b0, 3'd0, 0, 1, 2);
        lui(0, 20'hfffff);
        sw(0, 8);                     // x0 right after three writes to it
        op_r(1'b0, 3'd0, 3, 0, 1);
        sw(3, 12);
        nop();
        auipc(4, 20'h00000);
        sw(4, 16);
        run_prog();
        report_test("lui, auipc and x0", err0);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        for (int i = 0; i < IMEM_WORDS; i++)
            imem[i] = rv32e_pkg::NOP_INSTR;
        for (int i = 0; i < DMEM_WORDS; i++)
            dmem[i] = fill_word(i);
        test_reset();
        test_alu();
        test_forwarding();
        test_load_use();
        test_upper_x0();
        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/rv32e_core.sv ====
// RV32E five-stage core top; instruction and data memory must answer combinationally, no branches
`timescale 1ns/1ps
`default_nettype none

module rv32e_core (
    input  wire                        clk,
    input  wire                        rst_n,
    output logic [rv32e_pkg::XLEN-1:0] instr_addr_o,
    input  wire  [rv32e_pkg::XLEN-1:0] instr_data_i,
    output logic [rv32e_pkg::XLEN-1:0] mem_addr_o,
    output logic [rv32e_pkg::XLEN-1:0] mem_wdata_o,
    output logic                       mem_we_o,
    output logic                       mem_re_o,
    input  wire  [rv32e_pkg::XLEN-1:0] mem_rdata_i
);

    rv32e_pkg::instr_u         if_instr;
    logic [rv32e_pkg::XLEN-1:0] if_pc;
    logic [rv32e_pkg::XLEN-1:0] imm;
    logic [rv32e_pkg::XLEN-1:0] rs1_data;
    logic [rv32e_pkg::XLEN-1:0] rs2_data;
    logic                       stall;
    rv32e_pkg::id_ex_t          id_ex;
    rv32e_pkg::fwd_sel_e        fwd_a;
    rv32e_pkg::fwd_sel_e        fwd_b;
    rv32e_pkg::ex_mem_t         ex_mem;
    rv32e_pkg::wb_t             mem_wb;
    rv32e_pkg::wb_t             retired;

    fetch_stage u_fetch (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall_i      (stall),
        .instr_data_i (instr_data_i),
        .instr_addr_o (instr_addr_o),
        .instr_o      (if_instr),
        .pc_o         (if_pc)
    );

    imm_gen u_imm (
        .instr_i (if_instr),
        .imm_o   (imm)
    );

    reg_file u_rf (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_addr_i (if_instr.r_fmt.rs1[rv32e_pkg::REG_ADDR_W-1:0]),
        .rs2_addr_i (if_instr.r_fmt.rs2[rv32e_pkg::REG_ADDR_W-1:0]),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wr_i       (mem_wb)
    );

    pipe_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr_i    (if_instr),
        .pc_i       (if_pc),
        .imm_i      (imm),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .ex_mem_i   (ex_mem),
        .mem_wb_i   (mem_wb),
        .retired_i  (retired),
        .id_ex_o    (id_ex),
        .stall_o    (stall),
        .fwd_a_o    (fwd_a),
        .fwd_b_o    (fwd_b)
    );

    exec_stage u_exec (
        .clk         (clk),
        .rst_n       (rst_n),
        .id_ex_i     (id_ex),
        .fwd_a_i     (fwd_a),
        .fwd_b_i     (fwd_b),
        .mem_rdata_i (mem_rdata_i),
        .ex_mem_o    (ex_mem),
        .mem_wb_o    (mem_wb),
        .retired_o   (retired)
    );

    // Data port is driven by the EX/MEM register
    assign mem_addr_o  = ex_mem.result;
    assign mem_wdata_o = ex_mem.store_data;
    assign mem_we_o    = ex_mem.mem_we;
    assign mem_re_o    = ex_mem.mem_re;

endmodule

`default_nettype wire

// ==== verilog/exec_stage.sv ====
// Forwarding muxes, ALU and the EX/MEM, MEM/WB and retired registers; word loads only
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire rv32e_pkg::id_ex_t     id_ex_i,
    input  wire rv32e_pkg::fwd_sel_e   fwd_a_i,
    input  wire rv32e_pkg::fwd_sel_e   fwd_b_i,
    input  wire [rv32e_pkg::XLEN-1:0]  mem_rdata_i,
    output rv32e_pkg::ex_mem_t         ex_mem_o,
    output rv32e_pkg::wb_t             mem_wb_o,
    output rv32e_pkg::wb_t             retired_o
);

    logic [rv32e_pkg::XLEN-1:0] rs1_val;
    logic [rv32e_pkg::XLEN-1:0] rs2_val;
    logic [rv32e_pkg::XLEN-1:0] op_a;
    logic [rv32e_pkg::XLEN-1:0] op_b;
    logic [rv32e_pkg::XLEN-1:0] alu_res;
    logic [4:0]                 shamt;

    function automatic logic [rv32e_pkg::XLEN-1:0] fwd_mux(
        input rv32e_pkg::fwd_sel_e       sel,
        input logic [rv32e_pkg::XLEN-1:0] rf_val
    );
        case (sel)
            rv32e_pkg::FWD_EX_MEM:  return ex_mem_o.result;
            rv32e_pkg::FWD_MEM_WB:  return mem_wb_o.data;
            rv32e_pkg::FWD_RETIRED: return retired_o.data;
            default:                return rf_val;
        endcase
    endfunction

    always_comb begin
        rs1_val = fwd_mux(fwd_a_i, id_ex_i.rs1_data);
        rs2_val = fwd_mux(fwd_b_i, id_ex_i.rs2_data);

        case (id_ex_i.a_sel)
            rv32e_pkg::A_PC:   op_a = id_ex_i.pc;    // AUIPC
            rv32e_pkg::A_ZERO: op_a = '0;            // LUI
            default:           op_a = rs1_val;
        endcase
        op_b  = id_ex_i.b_imm ? id_ex_i.imm : rs2_val;
        shamt = op_b[4:0];

        case (id_ex_i.alu_op)
            rv32e_pkg::ALU_SUB:  alu_res = op_a - op_b;
            rv32e_pkg::ALU_SLL:  alu_res = op_a << shamt;
            rv32e_pkg::ALU_SLT:  alu_res = {{(rv32e_pkg::XLEN-1){1'b0}},
                                            $signed(op_a) < $signed(op_b)};
            rv32e_pkg::ALU_SLTU: alu_res = {{(rv32e_pkg::XLEN-1){1'b0}}, op_a < op_b};
            rv32e_pkg::ALU_XOR:  alu_res = op_a ^ op_b;
            rv32e_pkg::ALU_SRL:  alu_res = op_a >> shamt;
            rv32e_pkg::ALU_SRA:  alu_res = $unsigned($signed(op_a) >>> shamt);
            rv32e_pkg::ALU_OR:   alu_res = op_a | op_b;
            rv32e_pkg::ALU_AND:  alu_res = op_a & op_b;
            default:             alu_res = op_a + op_b;    // ADD, address calc
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem_o  <= '0;
            mem_wb_o  <= '0;
            retired_o <= '0;
        end else begin
            ex_mem_o.result     <= alu_res;
            ex_mem_o.store_data <= rs2_val;    // Forwarded rs2
            ex_mem_o.rd         <= id_ex_i.rd;
            ex_mem_o.mem_we     <= id_ex_i.mem_we;
            ex_mem_o.mem_re     <= id_ex_i.mem_re;
            ex_mem_o.reg_we     <= id_ex_i.reg_we;

            // Load data arrives in the same cycle as the address
            mem_wb_o.rd   <= ex_mem_o.rd;
            mem_wb_o.data <= ex_mem_o.mem_re ? mem_rdata_i : ex_mem_o.result;
            mem_wb_o.we   <= ex_mem_o.reg_we;

            // One more cycle covers the readers of the register file before the write
            retired_o <= mem_wb_o;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/pipe_ctrl.sv ====
// Decode, ID/EX register and hazard control; unknown opcodes decode as NOPs, stall check is conservative
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire rv32e_pkg::instr_u        instr_i,
    input  wire [rv32e_pkg::XLEN-1:0]     pc_i,
    input  wire [rv32e_pkg::XLEN-1:0]     imm_i,
    input  wire [rv32e_pkg::XLEN-1:0]     rs1_data_i,
    input  wire [rv32e_pkg::XLEN-1:0]     rs2_data_i,
    input  wire rv32e_pkg::ex_mem_t       ex_mem_i,
    input  wire rv32e_pkg::wb_t           mem_wb_i,
    input  wire rv32e_pkg::wb_t           retired_i,
    output rv32e_pkg::id_ex_t             id_ex_o,
    output logic                          stall_o,
    output rv32e_pkg::fwd_sel_e           fwd_a_o,
    output rv32e_pkg::fwd_sel_e           fwd_b_o
);

    logic [rv32e_pkg::REG_ADDR_W-1:0] rs1_idx;
    logic [rv32e_pkg::REG_ADDR_W-1:0] rs2_idx;
    logic [rv32e_pkg::REG_ADDR_W-1:0] rd_idx;
    logic [2:0]                       funct3;
    logic                             r_alt;    // SUB or SRA in R-type
    logic                             i_alt;    // SRAI only
    rv32e_pkg::alu_op_e               alu_op;
    rv32e_pkg::a_sel_e                a_sel;
    logic                             b_imm;
    logic                             mem_we;
    logic                             mem_re;
    logic                             reg_we;

    assign rs1_idx = instr_i.r_fmt.rs1[rv32e_pkg::REG_ADDR_W-1:0];
    assign rs2_idx = instr_i.r_fmt.rs2[rv32e_pkg::REG_ADDR_W-1:0];
    assign rd_idx  = instr_i.r_fmt.rd[rv32e_pkg::REG_ADDR_W-1:0];
    assign funct3  = instr_i.r_fmt.funct3;
    assign r_alt   = instr_i.r_fmt.funct7[5] && (funct3 == 3'b000 || funct3 == 3'b101);
    assign i_alt   = instr_i.r_fmt.funct7[5] && (funct3 == 3'b101);

    always_comb begin
        alu_op = rv32e_pkg::ALU_ADD;
        a_sel  = rv32e_pkg::A_RS1;
        b_imm  = 1'b0;
        mem_we = 1'b0;
        mem_re = 1'b0;
        reg_we = 1'b0;
        case (instr_i.r_fmt.opcode)
            rv32e_pkg::OP_REG: begin
                alu_op = rv32e_pkg::alu_op_e'({r_alt, funct3});
                reg_we = 1'b1;
            end
            rv32e_pkg::OP_IMM: begin
                alu_op = rv32e_pkg::alu_op_e'({i_alt, funct3});
                b_imm  = 1'b1;
                reg_we = 1'b1;
            end
            rv32e_pkg::OP_LOAD: begin
                b_imm  = 1'b1;    // Address is rs1 + imm
                mem_re = 1'b1;
                reg_we = 1'b1;
            end
            rv32e_pkg::OP_STORE: begin
                b_imm  = 1'b1;
                mem_we = 1'b1;
            end
            rv32e_pkg::OP_LUI: begin
                a_sel  = rv32e_pkg::A_ZERO;
                b_imm  = 1'b1;
                reg_we = 1'b1;
            end
            rv32e_pkg::OP_AUIPC: begin
                a_sel  = rv32e_pkg::A_PC;
                b_imm  = 1'b1;
                reg_we = 1'b1;
            end
            default: ;    // FENCE, SYSTEM and the rest act as NOPs
        endcase
    end

    // Load in ID/EX whose rd is named by the instruction in IF/ID
    assign stall_o = id_ex_o.mem_re && (id_ex_o.rd != '0) &&
                     ((id_ex_o.rd == rs1_idx) || (id_ex_o.rd == rs2_idx));

    // Nearest producer wins; a load never forwards from EX/MEM
    function automatic rv32e_pkg::fwd_sel_e pick_src(
        input logic [rv32e_pkg::REG_ADDR_W-1:0] src
    );
        if (src == '0)
            return rv32e_pkg::FWD_REGFILE;
        else if (ex_mem_i.reg_we && !ex_mem_i.mem_re && ex_mem_i.rd == src)
            return rv32e_pkg::FWD_EX_MEM;
        else if (mem_wb_i.we && mem_wb_i.rd == src)
            return rv32e_pkg::FWD_MEM_WB;
        else if (retired_i.we && retired_i.rd == src)
            return rv32e_pkg::FWD_RETIRED;
        return rv32e_pkg::FWD_REGFILE;
    endfunction

    always_comb begin
        fwd_a_o = pick_src(id_ex_o.rs1);
        fwd_b_o = pick_src(id_ex_o.rs2);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex_o <= '0;
        end else begin
            id_ex_o.pc       <= pc_i;
            id_ex_o.rs1_data <= rs1_data_i;
            id_ex_o.rs2_data <= rs2_data_i;
            id_ex_o.imm      <= imm_i;
            id_ex_o.rs1      <= rs1_idx;
            id_ex_o.rs2      <= rs2_idx;
            id_ex_o.rd       <= rd_idx;
            id_ex_o.alu_op   <= alu_op;
            id_ex_o.a_sel    <= a_sel;
            id_ex_o.b_imm    <= b_imm;
            id_ex_o.mem_we   <= mem_we && !stall_o;    // Bubble on stall
            id_ex_o.mem_re   <= mem_re && !stall_o;
            id_ex_o.reg_we   <= reg_we && !stall_o;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/reg_file.sv ====
// 16-entry register file with combinational reads and no write-through; x0 stays zero
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire [rv32e_pkg::REG_ADDR_W-1:0]  rs1_addr_i,
    input  wire [rv32e_pkg::REG_ADDR_W-1:0]  rs2_addr_i,
    output logic [rv32e_pkg::XLEN-1:0]       rs1_data_o,
    output logic [rv32e_pkg::XLEN-1:0]       rs2_data_o,
    input  wire rv32e_pkg::wb_t              wr_i
);

    logic [rv32e_pkg::XLEN-1:0] regs [0:(1 << rv32e_pkg::REG_ADDR_W)-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < (1 << rv32e_pkg::REG_ADDR_W); i++)
                regs[i] <= '0;
        end else if (wr_i.we && wr_i.rd != '0) begin
            regs[wr_i.rd] <= wr_i.data;    // x0 is never written
        end
    end

    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];

endmodule

`default_nettype wire

// ==== verilog/imm_gen.sv ====
// Immediate builder for I, S and U formats; other opcodes give zero
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
    input  wire rv32e_pkg::instr_u     instr_i,
    output logic [rv32e_pkg::XLEN-1:0] imm_o
);

    logic [11:0] s_imm;

    assign s_imm = {instr_i.s_fmt.imm_hi, instr_i.s_fmt.imm_lo};

    always_comb begin
        case (instr_i.r_fmt.opcode)
            rv32e_pkg::OP_IMM,
            rv32e_pkg::OP_LOAD: begin
                imm_o = {{(rv32e_pkg::XLEN-12){instr_i.i_fmt.imm12[11]}},
                         instr_i.i_fmt.imm12};
            end
            rv32e_pkg::OP_STORE: begin
                imm_o = {{(rv32e_pkg::XLEN-12){s_imm[11]}}, s_imm};
            end
            rv32e_pkg::OP_LUI,
            rv32e_pkg::OP_AUIPC: begin
                imm_o = {instr_i.u_fmt.imm20, 12'b0};    // Upper 20 bits, low bits zero
            end
            default: begin
                imm_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/fetch_stage.sv ====
// PC and IF/ID register; PC only advances by 4, instruction memory must answer in the same cycle
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        stall_i,
    input  wire  [rv32e_pkg::XLEN-1:0] instr_data_i,
    output logic [rv32e_pkg::XLEN-1:0] instr_addr_o,
    output rv32e_pkg::instr_u          instr_o,
    output logic [rv32e_pkg::XLEN-1:0] pc_o
);

    logic [rv32e_pkg::XLEN-1:0] pc_q;

    assign instr_addr_o = pc_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q    <= rv32e_pkg::RESET_PC;
            instr_o <= rv32e_pkg::NOP_INSTR;
            pc_o    <= rv32e_pkg::RESET_PC;
        end else if (!stall_i) begin
            pc_q    <= pc_q + rv32e_pkg::XLEN'(4);
            instr_o <= instr_data_i;
            pc_o    <= pc_q;    // PC of the word now in IF/ID
        end
        // Stalled: PC and IF/ID keep their values
    end

endmodule

`default_nettype wire

// ==== verilog/rv32e_pkg.sv ====
// Shared RV32E types; word loads/stores only, branches and system opcodes are not encoded here
`default_nettype none

package rv32e_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 4;    // RV32E uses the low 4 bits of each register field

    localparam logic [XLEN-1:0] RESET_PC  = 32'h8000_0000;
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;    // ADDI x0, x0, 0

    localparam logic [6:0] OP_REG   = 7'b0110011;
    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;
    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // Same instruction word, four field layouts
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        u_fmt_t u_fmt;
    } instr_u;

    // Encoded as {funct7[5], funct3}
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SUB  = 4'b1000,
        ALU_SRA  = 4'b1101
    } alu_op_e;

    typedef enum logic [1:0] {A_RS1, A_PC, A_ZERO} a_sel_e;

    typedef enum logic [1:0] {FWD_REGFILE, FWD_EX_MEM, FWD_MEM_WB, FWD_RETIRED} fwd_sel_e;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [XLEN-1:0]       imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        alu_op_e               alu_op;
        a_sel_e                a_sel;
        logic                  b_imm;    // Operand B from the immediate
        logic                  mem_we;
        logic                  mem_re;
        logic                  reg_we;
    } id_ex_t;

    typedef struct packed {
        logic [XLEN-1:0]       result;    // ALU result or memory address
        logic [XLEN-1:0]       store_data;
        logic [REG_ADDR_W-1:0] rd;
        logic                  mem_we;
        logic                  mem_re;
        logic                  reg_we;
    } ex_mem_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
        logic                  we;
    } wb_t;

endpackage

`default_nettype wire
